/* logic/acq_ctrl_if.sv */
//----------------------------
// settings and status between command engine and acquisition
// arm and readout_done are single-cycle pulses
//----------------------------
`timescale 1ns/1ns

interface acq_ctrl_if #(
	parameter int DEPTH_W = scope_pkg::addr_w
) ();

// written by the command engine
scope_pkg::trig_type_e                 trig_type;
logic signed [scope_pkg::sample_w-1:0] lower_thresh;
logic signed [scope_pkg::sample_w-1:0] upper_thresh;
logic [7:0]                            tot;            // samples over threshold before trigger
logic [15:0]                           length_to_take; // post-trigger samples
logic                                  arm;
logic                                  readout_done;

// written by acquisition
scope_pkg::acq_state_e                 acq_state;
logic [7:0]                            event_count;
logic [DEPTH_W-1:0]                    trig_addr;      // buffer address of trigger sample

modport ctrl (
	output trig_type, lower_thresh, upper_thresh, tot, length_to_take, arm, readout_done,
	input  acq_state, event_count, trig_addr
);

modport acq (
	input  trig_type, lower_thresh, upper_thresh, tot, length_to_take, arm, readout_done,
	output acq_state, event_count, trig_addr
);

endinterface

/* logic/acq_trigger.sv */
//----------------------------
// trigger fsm and buffer write pointer
// writes every clk until ACQ_READY, holds until readout_done
// unknown trigger types act as TRIG_NOW
//----------------------------
`timescale 1ns/1ns

module acq_trigger #(
	parameter int DEPTH_W = scope_pkg::addr_w
) (
	input  logic                                 clk,
	input  logic                                 rstn,
	input  logic signed [scope_pkg::sample_w-1:0] i_sample,
	input  logic                                 i_ext_trig,
	acq_ctrl_if.acq                              ctl,
	output logic                                 o_wr,
	output logic [DEPTH_W-1:0]                   o_wr_addr,
	output logic                                 o_trig_out
);

scope_pkg::acq_state_e state, state_nxt;
logic               run;       // low only in the first clk after reset
logic               trig_hit;  // trigger condition met this clk
logic               post_last; // this clk is the final post-trigger write
logic [7:0]         tot_cnt;   // consecutive samples past second threshold
logic [15:0]        post_cnt;
logic [7:0]         event_cnt;
logic [DEPTH_W-1:0] trig_addr;

assign o_wr      = run && (state != scope_pkg::ACQ_READY);
assign post_last = ({1'b0, post_cnt} + 17'd1) >= {1'b0, ctl.length_to_take};

assign ctl.acq_state   = state;
assign ctl.event_count = event_cnt;
assign ctl.trig_addr   = trig_addr;

//----------------------------
// next state
//----------------------------
always_comb begin
	state_nxt = state;
	trig_hit  = 1'b0;
	case (state)
	scope_pkg::ACQ_IDLE: begin
		if (ctl.arm) begin
			case (ctl.trig_type)
			scope_pkg::TRIG_RISE: state_nxt = scope_pkg::ACQ_RISE_LOW;
			scope_pkg::TRIG_FALL: state_nxt = scope_pkg::ACQ_FALL_HIGH;
			scope_pkg::TRIG_EXT:  state_nxt = scope_pkg::ACQ_EXT_WAIT;
			default:              trig_hit  = 1'b1; // immediate
			endcase
		end
	end
	scope_pkg::ACQ_RISE_LOW: begin
		if (ctl.trig_type != scope_pkg::TRIG_RISE) state_nxt = scope_pkg::ACQ_IDLE;
		else if (i_sample < ctl.lower_thresh) state_nxt = scope_pkg::ACQ_RISE_HIGH;
	end
	scope_pkg::ACQ_RISE_HIGH: begin
		if (ctl.trig_type != scope_pkg::TRIG_RISE) state_nxt = scope_pkg::ACQ_IDLE;
		else if (i_sample > ctl.upper_thresh) trig_hit = (tot_cnt >= ctl.tot);
		else state_nxt = scope_pkg::ACQ_RISE_LOW; // dropped back, rearm edge
	end
	scope_pkg::ACQ_FALL_HIGH: begin
		if (ctl.trig_type != scope_pkg::TRIG_FALL) state_nxt = scope_pkg::ACQ_IDLE;
		else if (i_sample > ctl.upper_thresh) state_nxt = scope_pkg::ACQ_FALL_LOW;
	end
	scope_pkg::ACQ_FALL_LOW: begin
		if (ctl.trig_type != scope_pkg::TRIG_FALL) state_nxt = scope_pkg::ACQ_IDLE;
		else if (i_sample < ctl.lower_thresh) trig_hit = (tot_cnt >= ctl.tot);
		else state_nxt = scope_pkg::ACQ_FALL_HIGH;
	end
	scope_pkg::ACQ_EXT_WAIT: begin
		if (ctl.trig_type != scope_pkg::TRIG_EXT) state_nxt = scope_pkg::ACQ_IDLE;
		else trig_hit = i_ext_trig;
	end
	scope_pkg::ACQ_POST: begin
		if (post_last) state_nxt = scope_pkg::ACQ_READY;
	end
	scope_pkg::ACQ_READY: begin
		if (ctl.readout_done) state_nxt = scope_pkg::ACQ_IDLE; // buffer released
	end
	default: state_nxt = scope_pkg::ACQ_IDLE;
	endcase
	if (trig_hit) state_nxt = scope_pkg::ACQ_POST;
end

//----------------------------
// registers
//----------------------------
always_ff @(posedge clk or negedge rstn) begin
	if (!rstn) begin
		state      <= scope_pkg::ACQ_IDLE;
		run        <= 1'b0;
		o_wr_addr  <= '0;
		trig_addr  <= '0;
		tot_cnt    <= '0;
		post_cnt   <= '0;
		event_cnt  <= '0;
		o_trig_out <= 1'b0;
	end else begin
		state      <= state_nxt;
		run        <= 1'b1;
		o_trig_out <= trig_hit; // one clk pulse to the outside
		if (o_wr) o_wr_addr <= o_wr_addr + 1'b1; // free running, wraps
		if (trig_hit) trig_addr <= o_wr_addr;     // address of the trigger sample
		// count only while staying in the second half of an edge trigger
		if ((state_nxt == state) &&
		    (state == scope_pkg::ACQ_RISE_HIGH || state == scope_pkg::ACQ_FALL_LOW)) begin
			tot_cnt <= tot_cnt + 8'd1;
		end else begin
			tot_cnt <= '0;
		end
		if (state == scope_pkg::ACQ_POST) post_cnt <= post_cnt + 16'd1;
		else post_cnt <= '0;
		if (state == scope_pkg::ACQ_POST && post_last) event_cnt <= event_cnt + 8'd1;
	end
end

endmodule

/* logic/cmd_engine.sv */
//----------------------------
// 8-byte command receiver, decoder and 32-bit reply streamer
// readout words carry two samples, length is floored to whole words
//----------------------------
`timescale 1ns/1ns

module cmd_engine #(
	parameter logic [31:0] VERSION = 32'd18,
	parameter int          DEPTH_W = scope_pkg::addr_w
) (
	input  logic                          clk,
	input  logic                          rstn,
	input  logic                          i_tvalid,
	input  logic [7:0]                    i_tdata,
	output logic                          o_tready,
	input  logic                          i_oready,
	output logic                          o_tvalid,
	output logic                          o_tlast,
	output logic [31:0]                   o_tdata,
	output logic [3:0]                    o_tkeep,
	acq_ctrl_if.ctrl                      ctl,
	output logic [DEPTH_W-1:0]            o_rd_addr,
	input  logic [scope_pkg::sample_w-1:0] i_rd_data
);

localparam int SW    = scope_pkg::sample_w;
localparam int CNT_W = $clog2(scope_pkg::cmd_bytes);
localparam int PAD_W = 16 - SW; // zero bits above each sample in a word

typedef enum logic [2:0] {
	ST_RX,     // collecting command bytes
	ST_DECODE, // act on opcode
	ST_RD0,    // present sample address
	ST_RD1,    // lower sample arrives
	ST_RD2,    // upper sample arrives, build word
	ST_SEND    // word on the stream, wait for ready
} eng_state_e;

eng_state_e         state;
logic [CNT_W-1:0]   rx_cnt;
logic [7:0]         rx_data [scope_pkg::cmd_bytes];
logic [29:0]        words_left;
logic               is_readout; // release buffer after last word
logic [9:0]         pre_offset;
logic [SW-1:0]      lo_sample;
logic [SW-1:0]      byte1, byte2;
logic [SW-1:0]      thr_lo, thr_hi;
logic [31:0]        rd_len;

assign o_tready = (state == ST_RX);
assign o_tkeep  = 4'b1111; // whole words only

// threshold math in sample width, x16 then +8 lands mid-step
assign byte1  = {{(SW-8){1'b0}}, rx_data[1]};
assign byte2  = {{(SW-8){1'b0}}, rx_data[2]};
assign thr_lo = byte1 - byte2 - SW'(128);
assign thr_hi = byte1 + byte2 - SW'(128);
assign rd_len = {rx_data[7], rx_data[6], rx_data[5], rx_data[4]};

always_ff @(posedge clk) begin
	if (o_tready && i_tvalid) begin
		rx_data[rx_cnt] <= i_tdata; // byte 0 first
	end
end

//----------------------------
// command fsm
//----------------------------
always_ff @(posedge clk or negedge rstn) begin
	if (!rstn) begin
		state              <= ST_RX;
		rx_cnt             <= '0;
		words_left         <= '0;
		is_readout         <= 1'b0;
		pre_offset         <= '0;
		lo_sample          <= '0;
		o_rd_addr          <= '0;
		o_tvalid           <= 1'b0;
		o_tlast            <= 1'b0;
		o_tdata            <= '0;
		ctl.trig_type      <= scope_pkg::TRIG_NOW;
		ctl.lower_thresh   <= '0;
		ctl.upper_thresh   <= '0;
		ctl.tot            <= '0;
		ctl.length_to_take <= '0;
		ctl.arm            <= 1'b0;
		ctl.readout_done   <= 1'b0;
	end else begin
		ctl.arm          <= 1'b0; // pulses
		ctl.readout_done <= 1'b0;
		case (state)
		ST_RX: begin
			if (i_tvalid) begin
				rx_cnt <= rx_cnt + 1'b1; // wraps to 0 after the last byte
				if (rx_cnt == CNT_W'(scope_pkg::cmd_bytes - 1)) state <= ST_DECODE;
			end
		end
		ST_DECODE: begin
			words_left <= 30'd1; // single word reply unless readout
			is_readout <= 1'b0;
			o_tlast    <= 1'b1;
			o_tvalid   <= 1'b1;
			state      <= ST_SEND;
			case (scope_pkg::cmd_op_e'(rx_data[0]))
			scope_pkg::CMD_READOUT: begin
				o_rd_addr  <= ctl.trig_addr - DEPTH_W'(pre_offset); // look back before trigger
				words_left <= rd_len[31:2];
				is_readout <= 1'b1;
				o_tvalid   <= 1'b0;
				if (rd_len[31:2] == '0) begin
					ctl.readout_done <= 1'b1; // nothing to send, just release
					state <= ST_RX;
				end else begin
					state <= ST_RD0;
				end
			end
			scope_pkg::CMD_ARM: begin
				ctl.trig_type      <= scope_pkg::trig_type_e'(rx_data[1]);
				ctl.length_to_take <= {rx_data[5], rx_data[4]};
				ctl.arm            <= (ctl.acq_state == scope_pkg::ACQ_IDLE); // no rearm mid event
				o_tdata            <= {ctl.event_count, 16'd0, 8'(ctl.acq_state)};
			end
			scope_pkg::CMD_VERSION: begin
				o_tdata <= VERSION;
			end
			scope_pkg::CMD_TRIG_SET: begin
				ctl.lower_thresh <= {thr_lo[SW-5:0], 4'h8};
				ctl.upper_thresh <= {thr_hi[SW-5:0], 4'h8};
				pre_offset       <= {rx_data[4][1:0], rx_data[3]};
				ctl.tot          <= rx_data[5];
				o_tdata          <= 32'd8; // echo opcode
			end
			default: begin
				o_tlast  <= 1'b0; // unknown, drop silently
				o_tvalid <= 1'b0;
				state    <= ST_RX;
			end
			endcase
		end
		ST_RD0: begin
			o_rd_addr <= o_rd_addr + 1'b1; // ram latches first address now
			state     <= ST_RD1;
		end
		ST_RD1: begin
			lo_sample <= i_rd_data;
			o_rd_addr <= o_rd_addr + 1'b1; // ready for next word
			state     <= ST_RD2;
		end
		ST_RD2: begin
			o_tdata  <= {{PAD_W{1'b0}}, i_rd_data, {PAD_W{1'b0}}, lo_sample};
			o_tlast  <= (words_left == 30'd1);
			o_tvalid <= 1'b1;
			state    <= ST_SEND;
		end
		ST_SEND: begin
			if (i_oready) begin // word taken
				o_tvalid <= 1'b0;
				if (words_left == 30'd1) begin
					ctl.readout_done <= is_readout;
					state <= ST_RX;
				end else begin
					words_left <= words_left - 30'd1;
					state <= ST_RD0;
				end
			end
		end
		default: state <= ST_RX;
		endcase
	end
end

endmodule

/* logic/sample_buffer.sv */
//----------------------------
// circular sample ram, 2**DEPTH_W entries
// read data arrives one clk after the address
// read and write of one address in one clk returns old data
//----------------------------
`timescale 1ns/1ns

module sample_buffer #(
	parameter int DEPTH_W = scope_pkg::addr_w
) (
	input  logic                          i_clk,
	input  logic                          i_wr,
	input  logic [DEPTH_W-1:0]            i_wr_addr,
	input  logic [scope_pkg::sample_w-1:0] i_wr_data,
	input  logic [DEPTH_W-1:0]            i_rd_addr,
	output logic [scope_pkg::sample_w-1:0] o_rd_data
);

// write pointer wraps freely, so the ram always holds the
// last 2**DEPTH_W samples before the trigger as history
logic [scope_pkg::sample_w-1:0] mem [2**DEPTH_W];

always_ff @(posedge i_clk) begin
	if (i_wr) begin
		mem[i_wr_addr] <= i_wr_data; // one sample per clk while acquiring
	end
end

always_ff @(posedge i_clk) begin
	o_rd_data <= mem[i_rd_addr]; // registered read port
end

endmodule

/* logic/scope_top.sv */
//----------------------------
// acquisition core top, single clock domain
// byte command stream in, 32-bit word stream out
//----------------------------
`timescale 1ns/1ns

module scope_top #(
	parameter logic [31:0] VERSION = 32'd18,
	parameter int          DEPTH_W = scope_pkg::addr_w
) (
	input  logic                          clk,
	input  logic                          rstn,
	// command bytes from host
	input  logic                          i_tvalid,
	input  logic [7:0]                    i_tdata,
	output logic                          o_tready,
	// reply words to host
	input  logic                          i_oready,
	output logic                          o_tvalid,
	output logic                          o_tlast,
	output logic [31:0]                   o_tdata,
	output logic [3:0]                    o_tkeep,
	// adc side
	input  logic [scope_pkg::sample_w-1:0] i_sample,
	input  logic                          i_ext_trig,
	output logic                          o_trig_out
);

logic                          wr;
logic [DEPTH_W-1:0]            wr_addr;
logic [DEPTH_W-1:0]            rd_addr;
logic [scope_pkg::sample_w-1:0] rd_data;

acq_ctrl_if #(.DEPTH_W(DEPTH_W)) ctl_if ();

sample_buffer #(.DEPTH_W(DEPTH_W)) u_buffer (
	.i_clk     (clk),
	.i_wr      (wr),
	.i_wr_addr (wr_addr),
	.i_wr_data (i_sample), // sample lands at the pointer of its own clk
	.i_rd_addr (rd_addr),
	.o_rd_data (rd_data)
);

acq_trigger #(.DEPTH_W(DEPTH_W)) u_acq (
	.clk        (clk),
	.rstn       (rstn),
	.i_sample   (i_sample),
	.i_ext_trig (i_ext_trig),
	.ctl        (ctl_if.acq),
	.o_wr       (wr),
	.o_wr_addr  (wr_addr),
	.o_trig_out (o_trig_out)
);

cmd_engine #(.VERSION(VERSION), .DEPTH_W(DEPTH_W)) u_cmd (
	.clk       (clk),
	.rstn      (rstn),
	.i_tvalid  (i_tvalid),
	.i_tdata   (i_tdata),
	.o_tready  (o_tready),
	.i_oready  (i_oready),
	.o_tvalid  (o_tvalid),
	.o_tlast   (o_tlast),
	.o_tdata   (o_tdata),
	.o_tkeep   (o_tkeep),
	.ctl       (ctl_if.ctrl),
	.o_rd_addr (rd_addr),
	.i_rd_data (rd_data)
);

endmodule

/* package.sv */
//----------------------------
// shared widths and encodings of the acquisition core
// single channel, one signed sample per clk
//----------------------------

package scope_pkg;

	localparam int sample_w  = 12; // signed adc sample
	localparam int addr_w    = 10; // sample buffer address, 1024 entries
	localparam int cmd_bytes = 8;  // every host command is this long

	//----------------------------
	// host command opcodes, byte 0
	//----------------------------
	typedef enum logic [7:0] {
		CMD_READOUT  = 8'd0, // stream buffer from trigger point
		CMD_ARM      = 8'd1, // arm trigger, reply status
		CMD_VERSION  = 8'd2, // reply firmware version
		CMD_TRIG_SET = 8'd8  // thresholds, pre-offset, tot
	} cmd_op_e;

	typedef enum logic [7:0] {
		TRIG_NOW  = 8'd0, // no condition, trigger at arm
		TRIG_RISE = 8'd1, // below lower then above upper
		TRIG_FALL = 8'd2, // above upper then below lower
		TRIG_EXT  = 8'd3  // external trigger input
	} trig_type_e;

	// state codes are reported to the host in the status word
	typedef enum logic [7:0] {
		ACQ_IDLE      = 8'd0,
		ACQ_RISE_LOW  = 8'd1,   // waiting for sample below lower
		ACQ_RISE_HIGH = 8'd2,   // counting samples above upper
		ACQ_FALL_HIGH = 8'd3,   // waiting for sample above upper
		ACQ_FALL_LOW  = 8'd4,   // counting samples below lower
		ACQ_EXT_WAIT  = 8'd5,   // waiting for external trigger
		ACQ_POST      = 8'd250, // taking post-trigger samples
		ACQ_READY     = 8'd251  // event frozen in buffer
	} acq_state_e;

endpackage

/* run.sh */
#!/bin/sh
# build and run the scope_top testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_top -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" sim.log; then
	exit 1
fi
exit 0

/* sources.f */
package.sv
logic/acq_ctrl_if.sv
logic/sample_buffer.sv
logic/acq_trigger.sv
logic/cmd_engine.sv
logic/scope_top.sv
tests/tb_checker.sv
tests/tb_top.sv

/* tests/tb_checker.sv */
//------------------------------
// output stream checker, samples on the falling clk edge
// a word counts where valid and ready are both high
// o_trig_out is checked against the sample of the clk before it
//------------------------------
`timescale 1ns/1ns

module tb_checker (
	input  logic                                 clk,
	input  logic                                 rstn,
	input  logic                                 i_valid,    // dut o_tvalid
	input  logic                                 i_ready,    // i_oready as driven
	input  logic                                 i_last,
	input  logic [31:0]                          i_data,
	input  logic [3:0]                           i_keep,
	input  logic                                 i_step_end, // one clk, closes the step
	input  int                                   i_step,
	input  logic [1:0]                           i_rule,
	input  int                                   i_words,
	input  logic [31:0]                          i_value,
	input  logic                                 i_trig,     // dut o_trig_out
	input  logic signed [scope_pkg::sample_w-1:0] i_sample,
	input  logic signed [scope_pkg::sample_w-1:0] i_trig_exp, // expected trigger sample
	output int                                   o_errors,
	output int                                   o_steps,
	output int                                   o_words
);

localparam int SW = scope_pkg::sample_w;
localparam logic [1:0] R_EXACT  = 2'd0; // same codes as the stimulus table
localparam logic [1:0] R_STATUS = 2'd1;
localparam logic [1:0] R_SAW    = 2'd2;
localparam logic signed [SW-1:0] SAW_MIN = -12'sd512;
localparam logic signed [SW-1:0] SAW_MAX = 12'sd511;

int              word_idx;  // words of the current step
int              step_err;
logic            held;      // word was stalled at the last sample
logic            held_last;
logic [31:0]     held_data;
logic signed [SW-1:0] prev; // last sample seen in a readout
logic            trig_seen;   // o_trig_out at the last sample
logic signed [SW-1:0] smp_prev;    // i_sample at the last sample
logic signed [SW-1:0] trig_sample; // sample that fired the trigger

function automatic logic signed [SW-1:0] next_saw(input logic signed [SW-1:0] s);
	if (s == SAW_MAX) return SAW_MIN; // ramp wraps
	return s + 12'sd1;
endfunction

function automatic string rule_name(input logic [1:0] r);
	case (r)
	R_EXACT:  return "exact";
	R_STATUS: return "status";
	R_SAW:    return "readout";
	default:  return "no reply";
	endcase
endfunction

task automatic flag_value(input string name, input logic [31:0] exp, input logic [31:0] got);
	$display("ERR %0t %s: expected 0x%0h, got 0x%0h", $time, name, exp, got);
	step_err++;
endtask

//------------------------------
// per word compare
//------------------------------
task automatic compare_word();
	logic signed [SW-1:0] lo;
	logic signed [SW-1:0] hi;
	logic                 last_exp;
	lo       = i_data[SW-1:0];
	hi       = i_data[16 +: SW];
	last_exp = (word_idx == i_words - 1);
	o_words++;
	if (word_idx >= i_words) begin
		$display("%0t: step %0d sent word 0x%0h beyond the %0d expected", $time, i_step,
		         i_data, i_words);
		step_err++;
	end else begin
		if (i_keep !== 4'hf) flag_value("o_tkeep", 32'hf, 32'(i_keep));
		if (i_last !== last_exp) flag_value("o_tlast", 32'(last_exp), 32'(i_last));
		case (i_rule)
		R_EXACT: begin
			if (i_data !== i_value) flag_value("o_tdata", i_value, i_data);
		end
		R_STATUS: begin
			if (i_data[7:0] !== i_value[7:0]) flag_value("o_tdata acq_state", i_value, i_data);
			if (i_data[31:24] !== i_value[31:24]) flag_value("o_tdata event_count", i_value, i_data);
		end
		R_SAW: begin
			if (word_idx == 0) begin
				if (lo !== trig_sample) begin
					flag_value("o_tdata first sample", 32'(trig_sample), 32'(lo));
				end
			end else if (lo !== next_saw(prev)) begin
				flag_value("o_tdata lower sample", 32'(next_saw(prev)), 32'(lo));
			end
			if (hi !== next_saw(lo)) flag_value("o_tdata upper sample", 32'(next_saw(lo)), 32'(hi));
			if ({i_data[31:16+SW], i_data[15:SW]} !== '0) flag_value("o_tdata pad bits", 32'd0, i_data);
			prev = hi;
		end
		default: ;
		endcase
	end
	word_idx++;
endtask

task automatic close_step();
	if (word_idx != i_words) begin
		$display("%0t: step %0d returned %0d words where %0d were expected", $time, i_step,
		         word_idx, i_words);
		step_err++;
	end
	if (step_err == 0) $display("step %0d %s: pass, %0d words", i_step, rule_name(i_rule), word_idx);
	else $display("step %0d %s: FAIL, %0d errors", i_step, rule_name(i_rule), step_err);
	o_errors += step_err;
	o_steps++;
	word_idx = 0;
	step_err = 0;
endtask

always @(negedge clk) begin
	if (!rstn) begin
		o_errors    = 0;
		o_steps     = 0;
		o_words     = 0;
		word_idx    = 0;
		step_err    = 0;
		held        = 1'b0;
		prev        = '0;
		trig_seen   = 1'b0;
		smp_prev    = '0;
		trig_sample = '0;
	end else begin
		// a stalled word must stay put until it is taken
		if (held && !i_valid) begin
			$display("%0t: o_tvalid dropped before the word was taken", $time);
			step_err++;
		end else if (held) begin
			if (i_data !== held_data) flag_value("o_tdata while stalled", held_data, i_data);
			if (i_last !== held_last) flag_value("o_tlast while stalled", 32'(held_last), 32'(i_last));
		end
		held      = i_valid && !i_ready;
		held_data = i_data;
		held_last = i_last;
		// pulse comes one clk after the trigger sample
		if (i_trig) begin
			if (trig_seen) begin
				$display("%0t: o_trig_out stayed high for more than one clk", $time);
				step_err++;
			end
			trig_sample = smp_prev;
			if (trig_sample !== i_trig_exp) begin
				flag_value("o_trig_out sample", 32'(i_trig_exp), 32'(trig_sample));
			end
		end
		trig_seen = i_trig;
		smp_prev  = i_sample;
		if (i_valid && i_ready) compare_word();
		if (i_step_end) close_step();
	end
end

endmodule

/* tests/tb_top.sv */
//------------------------------
// testbench for scope_top, table driven
// sawtooth samples, random output back-pressure
// rising trigger uses lower above upper so a +1 ramp can fire it
//------------------------------
`timescale 1ns/1ns

module tb_top;

localparam int SW          = scope_pkg::sample_w;
localparam int N_MAX       = 16;   // table capacity
localparam int STEP_CYCLES = 4000; // watchdog budget per step
localparam logic [1:0] R_EXACT  = 2'd0;
localparam logic [1:0] R_STATUS = 2'd1;
localparam logic [1:0] R_SAW    = 2'd2;
localparam logic [1:0] R_NONE   = 2'd3;
localparam int PRE_NONE = 0;
localparam int PRE_SYNC = 1; // wait for the ramp before sending
localparam int PRE_TRIG = 2; // wait for trigger and post samples
localparam logic [31:0] EXP_VERSION = 32'd18;
localparam logic [7:0]  TRIG_B1    = 8'd136;
localparam logic [7:0]  NARROW_B2  = 8'd4;
localparam logic [7:0]  SWAP_B2    = 8'd252; // thresholds cross over, lower 200 upper 72
localparam logic [7:0]  TOT        = 8'd0;
localparam logic [7:0]  ARM_LEN    = 8'd100;
localparam logic [7:0]  READ_BYTES = 8'd16;
localparam logic signed [SW-1:0] SAW_MIN = -12'sd512;
localparam logic signed [SW-1:0] SAW_MAX = 12'sd511;

logic                 clk;
logic                 rstn;
logic                 i_tvalid;
logic [7:0]           i_tdata;
logic                 o_tready;
logic                 i_oready;
logic                 o_tvalid;
logic                 o_tlast;
logic [31:0]          o_tdata;
logic [3:0]           o_tkeep;
logic signed [SW-1:0] i_sample;
logic                 i_ext_trig;
logic                 o_trig_out;

//------------------------------
// stimulus table
//------------------------------
logic [63:0] tbl_cmd   [N_MAX]; // byte 0 in bits 7:0
logic [1:0]  tbl_rule  [N_MAX];
int          tbl_words [N_MAX];
logic [31:0] tbl_value [N_MAX];
int          tbl_pre   [N_MAX];
int          n_steps;
int          seed = 45;

logic                 step_end;
int                   cur_step;
logic [1:0]           cur_rule;
int                   cur_words;
logic [31:0]          cur_value;
logic signed [SW-1:0] trig_exp;
logic signed [SW-1:0] lower_thr;
logic signed [SW-1:0] upper_thr;
int                   errors;
int                   steps_seen;
int                   words_seen;

scope_top UUT (
	.clk        (clk),
	.rstn       (rstn),
	.i_tvalid   (i_tvalid),
	.i_tdata    (i_tdata),
	.o_tready   (o_tready),
	.i_oready   (i_oready),
	.o_tvalid   (o_tvalid),
	.o_tlast    (o_tlast),
	.o_tdata    (o_tdata),
	.o_tkeep    (o_tkeep),
	.i_sample   (i_sample),
	.i_ext_trig (i_ext_trig),
	.o_trig_out (o_trig_out)
);

tb_checker u_check (
	.clk        (clk),
	.rstn       (rstn),
	.i_valid    (o_tvalid),
	.i_ready    (i_oready),
	.i_last     (o_tlast),
	.i_data     (o_tdata),
	.i_keep     (o_tkeep),
	.i_step_end (step_end),
	.i_step     (cur_step),
	.i_rule     (cur_rule),
	.i_words    (cur_words),
	.i_value    (cur_value),
	.i_trig     (o_trig_out),
	.i_sample   (i_sample),
	.i_trig_exp (trig_exp),
	.o_errors   (errors),
	.o_steps    (steps_seen),
	.o_words    (words_seen)
);

function automatic logic [63:0] cmd8(input logic [7:0] b0, b1, b2, b3, b4, b5, b6, b7);
	return {b7, b6, b5, b4, b3, b2, b1, b0};
endfunction

function automatic logic [31:0] status_word(input logic [7:0] count, input logic [7:0] state);
	return {count, 16'd0, state};
endfunction

// 16 x (b1 -/+ b2 - 128) + 8, wrapped to the sample width
function automatic logic signed [SW-1:0] thresh_from_bytes(input int b1, input int b2,
                                                           input bit upper);
	int units;
	units = upper ? (b1 + b2 - 128) : (b1 - b2 - 128);
	return SW'(16 * units + 8);
endfunction

task automatic add_step(input logic [63:0] cmd, input logic [1:0] rule, input int words,
                        input logic [31:0] value, input int pre);
	tbl_cmd[n_steps]   = cmd;
	tbl_rule[n_steps]  = rule;
	tbl_words[n_steps] = words;
	tbl_value[n_steps] = value;
	tbl_pre[n_steps]   = pre;
	n_steps++;
endtask

task automatic build_table();
	logic [63:0] arm_cmd;
	n_steps   = 0;
	lower_thr = thresh_from_bytes(TRIG_B1, SWAP_B2, 1'b0);
	upper_thr = thresh_from_bytes(TRIG_B1, SWAP_B2, 1'b1);
	arm_cmd   = cmd8(scope_pkg::CMD_ARM, scope_pkg::TRIG_RISE, 8'd0, 8'd0, ARM_LEN, 8'd0, 8'd0, 8'd0);
	add_step(cmd8(scope_pkg::CMD_VERSION, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0),
	         R_EXACT, 1, EXP_VERSION, PRE_NONE);
	add_step(cmd8(scope_pkg::CMD_TRIG_SET, TRIG_B1, NARROW_B2, 8'd0, 8'd0, TOT, 8'd0, 8'd0),
	         R_EXACT, 1, 32'd8, PRE_NONE);
	add_step(cmd8(scope_pkg::CMD_TRIG_SET, TRIG_B1, SWAP_B2, 8'd0, 8'd0, TOT, 8'd0, 8'd0),
	         R_EXACT, 1, 32'd8, PRE_NONE);
	add_step(arm_cmd, R_STATUS, 1, status_word(8'd0, scope_pkg::ACQ_IDLE), PRE_SYNC);
	add_step(arm_cmd, R_STATUS, 1, status_word(8'd1, scope_pkg::ACQ_READY), PRE_TRIG);
	add_step(cmd8(scope_pkg::CMD_READOUT, 8'd0, 8'd0, 8'd0, READ_BYTES, 8'd0, 8'd0, 8'd0),
	         R_SAW, READ_BYTES / 4, 32'd0, PRE_NONE);
	add_step(arm_cmd, R_STATUS, 1, status_word(8'd1, scope_pkg::ACQ_IDLE), PRE_NONE);
	add_step(cmd8(8'd77, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0), R_NONE, 0, 32'd0, PRE_NONE);
	add_step(cmd8(scope_pkg::CMD_VERSION, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0),
	         R_EXACT, 1, EXP_VERSION, PRE_NONE);
endtask

//------------------------------
// stream handshakes, all entered 1 ns after a rising edge
//------------------------------
task automatic send_byte(input logic [7:0] b);
	i_tvalid = 1'b1;
	i_tdata  = b;
	@(negedge clk);
	while (!o_tready) @(negedge clk);
	@(posedge clk);
	#1;
	i_tvalid = 1'b0;
endtask

task automatic await_reply();
	@(negedge clk);
	while (!o_tready) @(negedge clk); // back in receive once the reply is out
	@(posedge clk);
	#1;
endtask

task automatic sync_to_sample(input logic signed [SW-1:0] v);
	@(negedge clk);
	while (i_sample != v) @(negedge clk);
	@(posedge clk);
	#1;
endtask

task automatic await_event_ready();
	@(negedge clk);
	while (!o_trig_out) @(negedge clk);
	repeat (int'(ARM_LEN) + 4) @(posedge clk); // post-trigger samples, then ready
	#1;
endtask

task automatic run_step(input int i);
	cur_step  = i;
	cur_rule  = tbl_rule[i];
	cur_words = tbl_words[i];
	cur_value = tbl_value[i];
	trig_exp  = upper_thr + 12'sd1 + SW'(TOT); // tot samples above upper, then the trigger
	case (tbl_pre[i])
	PRE_SYNC: sync_to_sample(lower_thr + 12'sd100); // arm above lower, search starts at the wrap
	PRE_TRIG: await_event_ready();
	default: ;
	endcase
	for (int k = 0; k < scope_pkg::cmd_bytes; k++) begin
		send_byte(tbl_cmd[i][8*k +: 8]);
	end
	await_reply();
	step_end = 1'b1;
	@(posedge clk);
	#1;
	step_end = 1'b0;
endtask

initial begin
	clk = 1'b0;
	forever #5 clk = ~clk;
end

initial begin
	i_sample = SAW_MIN;
	forever begin
		@(posedge clk);
		#1;
		i_sample = (i_sample == SAW_MAX) ? SAW_MIN : i_sample + 12'sd1;
	end
end

initial begin
	i_oready = 1'b0;
	forever begin
		@(posedge clk);
		#1;
		i_oready = ($random(seed) % 4) != 0; // stall about one cycle in four
	end
end

initial begin
	#1;
	repeat (STEP_CYCLES * n_steps) @(posedge clk);
	$display("watchdog: run still busy in step %0d after %0d cycles", cur_step,
	         STEP_CYCLES * n_steps);
	$display("Test FAILED");
	$finish;
end

initial begin
	rstn       = 1'b0;
	i_tvalid   = 1'b0;
	i_tdata    = 8'd0;
	i_ext_trig = 1'b0;
	step_end   = 1'b0;
	cur_step   = 0;
	cur_rule   = R_NONE;
	cur_words  = 0;
	cur_value  = 32'd0;
	trig_exp   = '0;
	build_table();
	repeat (3) @(posedge clk);
	#1;
	rstn = 1'b1;
	for (int i = 0; i < n_steps; i++) begin
		run_step(i);
	end
	repeat (4) @(posedge clk);
	$display("steps %0d of %0d, words %0d, errors %0d", steps_seen, n_steps, words_seen, errors);
	if (errors == 0 && steps_seen == n_steps) begin
		$display("Test OK");
	end else begin
		$display("Test FAILED");
	end
	$finish;
end

endmodule
